/* vlog.f */
+incdir+rtl
rtl/isa_pkg.sv
rtl/micro_pkg.sv
rtl/byte_fetch.sv
rtl/opcode_decode.sv
rtl/micro_sequencer.sv
rtl/micro_issue.sv
rtl/decode_top.sv
verification/decode_assert.sv
verification/decode_tb.sv

/* Bender.yml */
package:
  name: decode_stage

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/isa_pkg.sv
      - rtl/micro_pkg.sv
      - rtl/byte_fetch.sv
      - rtl/opcode_decode.sv
      - rtl/micro_sequencer.sv
      - rtl/micro_issue.sv
      - rtl/decode_top.sv
  - target: simulation
    files:
      - verification/decode_assert.sv
      - verification/decode_tb.sv

/* verification/decode_tb.sv */
`timescale 1ns/1ns

module decode_tb;

  import isa_pkg::*;
  import micro_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;
  localparam int TIMEOUT     = 100;

  logic        clk;
  logic        rst;
  logic        byte_req;
  logic [7:0]  byte_data;
  logic        byte_ack;
  micro_word_t uop_word;
  logic        uop_req;
  logic        uop_ack;
  logic        intr;
  logic        ifl;
  logic        div_exc;
  logic        inta;

  // stimulus and expected micro-words, consumed in order
  logic [7:0]  byte_q[$];
  micro_word_t exp_q[$];

  integer seed = 63;
  int     errors = 0;
  int     errors_at_start = 0;
  int     assert_fails_seen = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     inta_count = 0;
  // word index that gets div_exc with its ack, -1 for none
  int     div_at = -1;
  int     max_delay = 3;
  bit     timed_out = 1'b0;
  string  test_name;

  decode_top UUT (
    .clk       (clk),
    .rst       (rst),
    .byte_req  (byte_req),
    .byte_data (byte_data),
    .byte_ack  (byte_ack),
    .uop_word  (uop_word),
    .uop_req   (uop_req),
    .uop_ack   (uop_ack),
    .intr      (intr),
    .ifl       (ifl),
    .div_exc   (div_exc),
    .inta      (inta)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // inta pulses seen over the whole run
  always @(posedge clk) begin
    if (inta === 1'b1) inta_count++;
  end

  // all driving and sampling happens just after the edge
  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic show_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    errors++;
  endtask

  task automatic wait_byte_ack(input logic level);
    int n;
    n = 0;
    while (byte_ack !== level && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (byte_ack !== level) begin
      $display("timed out waiting for byte_ack to go %s", level ? "high" : "low");
      timed_out = 1'b1;
      errors++;
    end
  endtask

  task automatic wait_uop_req(input logic level);
    int n;
    n = 0;
    while (uop_req !== level && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (uop_req !== level) begin
      $display("timed out waiting for uop_req to go %s", level ? "high" : "low");
      timed_out = 1'b1;
      errors++;
    end
  endtask

  // one four-phase byte exchange with the fetch side
  task automatic send_byte(input logic [7:0] value);
    byte_data = value;
    byte_req  = 1'b1;
    wait_byte_ack(1'b1);
    byte_req  = 1'b0;
    wait_byte_ack(1'b0);
  endtask

  task automatic send_bytes();
    while (byte_q.size() > 0 && !timed_out) begin
      send_byte(byte_q.pop_front());
    end
  endtask

  task automatic push_word(input uop_e uop, input reg_idx_t src, input reg_idx_t dst,
                           input logic [15:0] data, input logic last);
    micro_word_t w;
    w.uop  = uop;
    w.src  = src;
    w.dst  = dst;
    w.data = data;
    w.last = last;
    exp_q.push_back(w);
  endtask

  // byte stream and routine of one instruction, from the isa table
  task automatic add_instr(input logic [7:0] op, input logic [7:0] modrm,
                           input logic [15:0] operand);
    byte_q.push_back(op);
    if (op[7:3] == 5'b10111) begin
      // mov r16,imm16, register in the low opcode bits
      byte_q.push_back(operand[7:0]);
      byte_q.push_back(operand[15:8]);
      push_word(uop_ld_imm, 3'd0, op[2:0], operand, 1'b0);
      push_word(uop_wr_reg, 3'd0, op[2:0], operand, 1'b1);
    end else begin
      case (op)
        8'h90: push_word(uop_nop, 3'd0, 3'd0, 16'h0000, 1'b1);
        8'h01: begin
          // register form, src from reg field, dst from r/m
          byte_q.push_back(modrm);
          push_word(uop_rd_a, modrm[5:3], modrm[2:0], 16'h0000, 1'b0);
          push_word(uop_rd_b, modrm[5:3], modrm[2:0], 16'h0000, 1'b0);
          push_word(uop_alu_add, modrm[5:3], modrm[2:0], 16'h0000, 1'b1);
        end
        8'hE9: begin
          byte_q.push_back(operand[7:0]);
          byte_q.push_back(operand[15:8]);
          push_word(uop_ld_off, 3'd0, 3'd0, operand, 1'b0);
          push_word(uop_jump, 3'd0, 3'd0, operand, 1'b1);
        end
        8'hF4: push_word(uop_halt, 3'd0, 3'd0, 16'h0000, 1'b1);
        // invalid opcode, no trailing bytes
        default: begin
          push_word(uop_trap_ud, 3'd0, 3'd0, 16'h0000, 1'b0);
          push_word(uop_vector, 3'd0, 3'd0, 16'h0000, 1'b1);
        end
      endcase
    end
  endtask

  // EINT and INTD have the same words
  task automatic add_trap_routine();
    push_word(uop_push_flags, 3'd0, 3'd0, 16'h0000, 1'b0);
    push_word(uop_vector, 3'd0, 3'd0, 16'h0000, 1'b0);
    push_word(uop_jump, 3'd0, 3'd0, 16'h0000, 1'b1);
  endtask

  task automatic compare_word(input micro_word_t got, input micro_word_t exp);
    assert (got.uop == exp.uop) else show_mismatch("uop_word.uop", got.uop, exp.uop);
    assert (got.src == exp.src) else show_mismatch("uop_word.src", got.src, exp.src);
    assert (got.dst == exp.dst) else show_mismatch("uop_word.dst", got.dst, exp.dst);
    assert (got.data == exp.data) else show_mismatch("uop_word.data", got.data, exp.data);
    assert (got.last == exp.last) else show_mismatch("uop_word.last", got.last, exp.last);
  endtask

  // execution unit side, random ack delay per word
  task automatic receive_words();
    micro_word_t exp;
    int          idx;
    int          delay;
    idx = 0;
    while (exp_q.size() > 0 && !timed_out) begin
      exp = exp_q.pop_front();
      wait_uop_req(1'b1);
      if (!timed_out) begin
        compare_word(uop_word, exp);
        delay = $unsigned($random(seed)) % (max_delay + 1);
        repeat (delay) next_cycle();
        uop_ack = 1'b1;
        div_exc = (idx == div_at);
        wait_uop_req(1'b0);
        uop_ack = 1'b0;
        div_exc = 1'b0;
      end
      idx++;
    end
  endtask

  // no extra word may follow the expected ones
  task automatic expect_idle(input int cycles);
    repeat (cycles) begin
      next_cycle();
      if (!timed_out) begin
        assert (uop_req == 1'b0) else show_mismatch("uop_req", uop_req, 1'b0);
      end
    end
  endtask

  // fetch and execution sides run side by side
  task automatic run_stream();
    fork
      send_bytes();
      receive_words();
    join
    expect_idle(8);
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
    tests_run++;
  endtask

  task automatic end_test();
    int new_fails;
    // bound assertion failures count against the running test
    new_fails         = UUT.u_assert.fail_count - assert_fails_seen;
    assert_fails_seen = UUT.u_assert.fail_count;
    errors            = errors + new_fails;
    if (errors != errors_at_start) begin
      $display("test %s: %0d error(s)", test_name, errors - errors_at_start);
      tests_failed++;
    end else if (timed_out) begin
      $display("test %s: not run after an earlier timeout", test_name);
      tests_failed++;
    end else begin
      $display("test %s: ok", test_name);
    end
  endtask

  task automatic run_instr(input string name, input logic [7:0] op,
                           input logic [7:0] modrm, input logic [15:0] operand);
    start_test(name);
    add_instr(op, modrm, operand);
    run_stream();
    end_test();
  endtask

  initial begin
    int inta_before;
    rst       = 1'b1;
    byte_req  = 1'b0;
    byte_data = 8'h00;
    uop_ack   = 1'b0;
    intr      = 1'b0;
    ifl       = 1'b0;
    div_exc   = 1'b0;
    repeat (5) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;

    // nothing moves until a byte is offered
    start_test("idle after reset");
    repeat (10) begin
      next_cycle();
      assert (byte_ack == 1'b0) else show_mismatch("byte_ack", byte_ack, 1'b0);
      assert (uop_req == 1'b0) else show_mismatch("uop_req", uop_req, 1'b0);
      assert (inta == 1'b0) else show_mismatch("inta", inta, 1'b0);
    end
    end_test();

    run_instr("nop", 8'h90, 8'h00, 16'h0000);
    run_instr("mov bx,imm16", 8'hBB, 8'h00, 16'h1234);
    run_instr("add reg form", 8'h01, 8'hC3, 16'h0000);
    run_instr("jmp rel16", 8'hE9, 8'h00, 16'hFF00);
    run_instr("hlt", 8'hF4, 8'h00, 16'h0000);
    run_instr("invalid opcode", 8'h0F, 8'h00, 16'h0000);

    // interrupt taken at the end of the mov
    start_test("interrupt with ifl high");
    inta_before = inta_count;
    intr        = 1'b1;
    ifl         = 1'b1;
    add_instr(8'hB9, 8'h00, 16'hA5A5);
    add_trap_routine();
    run_stream();
    intr = 1'b0;
    ifl  = 1'b0;
    assert (inta_count - inta_before == 1)
      else show_mismatch("inta pulses", inta_count - inta_before, 1);
    end_test();

    // masked, routine runs alone
    start_test("interrupt with ifl low");
    inta_before = inta_count;
    intr        = 1'b1;
    add_instr(8'h90, 8'h00, 16'h0000);
    run_stream();
    intr = 1'b0;
    assert (inta_count == inta_before)
      else show_mismatch("inta pulses", inta_count - inta_before, 0);
    end_test();

    // trap replaces rd_b and alu_add
    start_test("divide exception in add");
    byte_q.push_back(8'h01);
    byte_q.push_back(8'hD9);
    push_word(uop_rd_a, 3'd3, 3'd1, 16'h0000, 1'b0);
    add_trap_routine();
    div_at = 0;
    run_stream();
    div_at = -1;
    end_test();

    // longer ack delays, fetch overlaps the running routines
    start_test("random ack delays");
    max_delay = 7;
    add_instr(8'hB8, 8'h00, 16'h0001);
    add_instr(8'h01, 8'hCA, 16'h0000);
    add_instr(8'hE9, 8'h00, 16'h0040);
    add_instr(8'h90, 8'h00, 16'h0000);
    add_instr(8'hFF, 8'h00, 16'h0000);
    add_instr(8'hF4, 8'h00, 16'h0000);
    add_instr(8'hBF, 8'h00, 16'hBEEF);
    run_stream();
    max_delay = 3;
    end_test();

    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* verification/decode_assert.sv */
`timescale 1ns/1ns

module decode_assert (
  input logic                   clk,
  input logic                   rst,
  input logic                   byte_ack,
  input logic                   uop_req,
  input logic                   uop_ack,
  input micro_pkg::micro_word_t uop_word,
  input logic                   inta
);

  // failures seen so far, read by the testbench
  int fail_count = 0;

  // handshake outputs come out of reset low
  a_idle_after_reset: assert property (
    @(posedge clk) rst |=> (!uop_req && !byte_ack && !inta)
  ) else begin
    $error("uop_req, byte_ack or inta high right after reset");
    fail_count++;
  end

  // word held until the execution unit acks
  a_word_stable: assert property (
    @(posedge clk) disable iff (rst) (uop_req && !uop_ack) |=> $stable(uop_word)
  ) else begin
    $error("uop_word changed while uop_req waited for uop_ack");
    fail_count++;
  end

  // next request only after the previous ack dropped
  a_no_req_during_ack: assert property (
    @(posedge clk) disable iff (rst) $rose(uop_req) |-> !$past(uop_ack)
  ) else begin
    $error("uop_req rose while uop_ack was still high");
    fail_count++;
  end

  a_inta_one_cycle: assert property (
    @(posedge clk) disable iff (rst) inta |=> !inta
  ) else begin
    $error("inta held longer than one cycle");
    fail_count++;
  end

endmodule

// top level sees both the fetch and the issue handshakes
bind decode_top decode_assert u_assert (
  .clk      (clk),
  .rst      (rst),
  .byte_ack (byte_ack),
  .uop_req  (uop_req),
  .uop_ack  (uop_ack),
  .uop_word (uop_word),
  .inta     (inta)
);

/* rtl/decode_top.sv */
`timescale 1ns/1ns

`include "cpu_defs.svh"

module decode_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   byte_req,
  input  logic [7:0]             byte_data,
  output logic                   byte_ack,
  output micro_pkg::micro_word_t uop_word,
  output logic                   uop_req,
  input  logic                   uop_ack,
  input  logic                   intr,
  input  logic                   ifl,
  input  logic                   div_exc,
  output logic                   inta
);

  import isa_pkg::*;

  fetched_instr_t               instr;
  decoded_instr_t               dec;
  logic                         instr_valid;
  logic                         instr_taken;
  logic [`MICRO_ADDR_WIDTH-1:0] micro_addr;
  logic                         addr_valid;
  logic                         word_done;
  logic                         word_last;

  // input side
  byte_fetch u_fetch (
    .clk          (clk),
    .rst          (rst),
    .byte_req     (byte_req),
    .byte_data    (byte_data),
    .byte_ack     (byte_ack),
    .instr        (instr),
    .instr_valid  (instr_valid),
    .instr_taken  (instr_taken),
    .need_modrm   (dec.need_modrm),
    .need_operand (dec.need_operand)
  );

  opcode_decode u_decode (
    .instr (instr),
    .dec   (dec)
  );

  micro_sequencer u_seq (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr_taken (instr_taken),
    .dec         (dec),
    .micro_addr  (micro_addr),
    .addr_valid  (addr_valid),
    .word_done   (word_done),
    .word_last   (word_last),
    .intr        (intr),
    .ifl         (ifl),
    .div_exc     (div_exc),
    .uop_ack     (uop_ack),
    .inta        (inta)
  );

  // output side
  micro_issue u_issue (
    .clk        (clk),
    .rst        (rst),
    .micro_addr (micro_addr),
    .addr_valid (addr_valid),
    .uop_req    (uop_req),
    .uop_word   (uop_word),
    .uop_ack    (uop_ack),
    .word_done  (word_done),
    .word_last  (word_last),
    .src        (dec.src),
    .dst        (dec.dst),
    .operand    (instr.operand)
  );

endmodule

/* rtl/micro_issue.sv */
`timescale 1ns/1ns

`include "cpu_defs.svh"

module micro_issue (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [`MICRO_ADDR_WIDTH-1:0]  micro_addr,
  input  logic                          addr_valid,
  output logic                          uop_req,
  output micro_pkg::micro_word_t        uop_word,
  input  logic                          uop_ack,
  output logic                          word_done,
  output logic                          word_last,
  input  isa_pkg::reg_idx_t             src,
  input  isa_pkg::reg_idx_t             dst,
  input  logic [15:0]                   operand
);

  import isa_pkg::*;
  import micro_pkg::*;

  typedef struct packed {
    uop_e uop;
    logic last;
    logic use_op;
  } rom_entry_t;

  rom_entry_t  rom [`ROM_DEPTH];
  rom_entry_t  rom_q;
  logic        trap_q;
  reg_idx_t    src_q;
  reg_idx_t    dst_q;
  logic [15:0] operand_q;
  logic        loaded;
  logic        acked;
  logic        load;

  // routine table, unused slots end as a single nop
  always_comb begin
    for (int i = 0; i < `ROM_DEPTH; i++) begin
      rom[i] = '{uop_nop, 1'b1, 1'b0};
    end
    rom[`ENTRY_NOP]      = '{uop_nop, 1'b1, 1'b0};
    rom[`ENTRY_MOV]      = '{uop_ld_imm, 1'b0, 1'b1};
    rom[`ENTRY_MOV + 1]  = '{uop_wr_reg, 1'b1, 1'b1};
    rom[`ENTRY_ADD]      = '{uop_rd_a, 1'b0, 1'b0};
    rom[`ENTRY_ADD + 1]  = '{uop_rd_b, 1'b0, 1'b0};
    rom[`ENTRY_ADD + 2]  = '{uop_alu_add, 1'b1, 1'b0};
    rom[`ENTRY_JMP]      = '{uop_ld_off, 1'b0, 1'b1};
    rom[`ENTRY_JMP + 1]  = '{uop_jump, 1'b1, 1'b1};
    rom[`ENTRY_HLT]      = '{uop_halt, 1'b1, 1'b0};
    rom[`ENTRY_INV]      = '{uop_trap_ud, 1'b0, 1'b0};
    rom[`ENTRY_INV + 1]  = '{uop_vector, 1'b1, 1'b0};
    // EINT and INTD share the same shape
    rom[`ENTRY_EINT]     = '{uop_push_flags, 1'b0, 1'b0};
    rom[`ENTRY_EINT + 1] = '{uop_vector, 1'b0, 1'b0};
    rom[`ENTRY_EINT + 2] = '{uop_jump, 1'b1, 1'b0};
    rom[`ENTRY_INTD]     = '{uop_push_flags, 1'b0, 1'b0};
    rom[`ENTRY_INTD + 1] = '{uop_vector, 1'b0, 1'b0};
    rom[`ENTRY_INTD + 2] = '{uop_jump, 1'b1, 1'b0};
  end

  // one read per address, next address only after word_done
  assign load      = addr_valid && !loaded;
  assign word_done = acked && !uop_ack;
  assign word_last = rom_q.last;

  always_ff @(posedge clk) begin
    if (load) begin
      rom_q  <= rom[micro_addr];
      trap_q <= (micro_addr >= `ENTRY_EINT);
    end
  end

  // operand fields follow decode while idle, frozen during a routine
  always_ff @(posedge clk) begin
    if (!addr_valid) begin
      src_q     <= src;
      dst_q     <= dst;
      operand_q <= operand;
    end
  end

  // trap routines carry no register fields
  always_comb begin
    uop_word.uop  = rom_q.uop;
    uop_word.src  = trap_q ? '0 : src_q;
    uop_word.dst  = trap_q ? '0 : dst_q;
    uop_word.data = rom_q.use_op ? operand_q : 16'h0000;
    uop_word.last = rom_q.last;
  end

  // four-phase sender
  always_ff @(posedge clk) begin
    if (rst) begin
      loaded  <= 1'b0;
      uop_req <= 1'b0;
      acked   <= 1'b0;
    end else begin
      if (load) begin
        loaded <= 1'b1;
      end else if (word_done) begin
        loaded <= 1'b0;
      end
      // req rises the cycle after the rom read
      if (loaded && !uop_req && !acked && !uop_ack) begin
        uop_req <= 1'b1;
      end else if (uop_req && uop_ack) begin
        uop_req <= 1'b0;
        acked   <= 1'b1;
      end else if (word_done) begin
        acked <= 1'b0;
      end
    end
  end

endmodule

/* rtl/micro_sequencer.sv */
`timescale 1ns/1ns

`include "cpu_defs.svh"

module micro_sequencer (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          instr_valid,
  output logic                          instr_taken,
  input  isa_pkg::decoded_instr_t       dec,
  output logic [`MICRO_ADDR_WIDTH-1:0]  micro_addr,
  output logic                          addr_valid,
  input  logic                          word_done,
  input  logic                          word_last,
  input  logic                          intr,
  input  logic                          ifl,
  input  logic                          div_exc,
  input  logic                          uop_ack,
  output logic                          inta
);

  logic [`MICRO_ADDR_WIDTH-1:0] step;
  logic [`MICRO_ADDR_WIDTH-1:0] step_next;
  logic [`MICRO_ADDR_WIDTH-1:0] entry_addr;
  logic [`MICRO_ADDR_WIDTH-1:0] base_addr;
  logic                         ext_int;
  logic                         old_ext_int;
  logic                         dive;
  logic                         dive_req;
  logic                         start;

  // new instruction only when no routine is running
  assign start       = instr_valid && !addr_valid;
  assign instr_taken = start;

  // divide trap wins over the interrupt routine
  assign base_addr = dive ? `ENTRY_INTD : (ext_int ? `ENTRY_EINT : entry_addr);
  assign step_next = step + `MICRO_ADDR_WIDTH'd1;

  // entry of the running instruction
  always_ff @(posedge clk) begin
    if (start) entry_addr <= dec.entry;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      step       <= '0;
      micro_addr <= '0;
      addr_valid <= 1'b0;
      ext_int    <= 1'b0;
      dive       <= 1'b0;
      dive_req   <= 1'b0;
    end else begin
      // div_exc only looked at while the word is being acked
      if (addr_valid && uop_ack && div_exc && !dive) dive_req <= 1'b1;

      if (start) begin
        step       <= '0;
        micro_addr <= dec.entry;
        addr_valid <= 1'b1;
      end else if (word_done) begin
        if (dive_req) begin
          // abandon the rest, restart at INTD step 0
          dive_req   <= 1'b0;
          dive       <= 1'b1;
          step       <= '0;
          micro_addr <= `ENTRY_INTD;
        end else if (word_last) begin
          step <= '0;
          dive <= 1'b0;
          // instruction boundary, check for a pending interrupt
          if (intr && ifl && !ext_int) begin
            ext_int    <= 1'b1;
            micro_addr <= `ENTRY_EINT;
          end else begin
            ext_int    <= 1'b0;
            addr_valid <= 1'b0;
          end
        end else begin
          step       <= step_next;
          micro_addr <= base_addr + step_next;
        end
      end
    end
  end

  // one-cycle acknowledge on the rising edge of ext_int
  always_ff @(posedge clk) begin
    if (rst) begin
      old_ext_int <= 1'b0;
      inta        <= 1'b0;
    end else begin
      old_ext_int <= ext_int;
      inta        <= ext_int && !old_ext_int;
    end
  end

endmodule

/* rtl/opcode_decode.sv */
`timescale 1ns/1ns

`include "cpu_defs.svh"

module opcode_decode (
  input  isa_pkg::fetched_instr_t instr,
  output isa_pkg::decoded_instr_t dec
);

  import isa_pkg::*;

  logic is_mov;
  logic reg_form;

  // mov r16,imm16 covers a block of eight opcodes
  assign is_mov = (instr.opcode[7:3] == op_mov_ri[7:3]);

  // mod field 11 means register operand
  assign reg_form = (instr.modrm[7:6] == 2'b11);

  always_comb begin
    // unknown opcodes land in the invalid-opcode routine
    dec.entry        = `ENTRY_INV;
    dec.src          = '0;
    dec.dst          = '0;
    dec.need_modrm   = 1'b0;
    dec.need_operand = 1'b0;

    if (is_mov) begin
      dec.entry        = `ENTRY_MOV;
      dec.dst          = instr.opcode[2:0];
      dec.need_operand = 1'b1;
    end else begin
      case (instr.opcode)
        op_nop: dec.entry = `ENTRY_NOP;

        op_add_rm: begin
          // modrm needed regardless of form
          dec.need_modrm = 1'b1;
          // memory forms not supported, treated as invalid
          if (reg_form) begin
            dec.entry = `ENTRY_ADD;
            dec.dst   = instr.modrm[2:0];
            dec.src   = instr.modrm[5:3];
          end
        end

        op_jmp_rel: begin
          dec.entry        = `ENTRY_JMP;
          dec.need_operand = 1'b1;
        end

        op_hlt: dec.entry = `ENTRY_HLT;

        default: begin
          dec.entry = `ENTRY_INV;
        end
      endcase
    end
  end

endmodule

/* rtl/byte_fetch.sv */
`timescale 1ns/1ns

module byte_fetch (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    byte_req,
  input  logic [7:0]              byte_data,
  output logic                    byte_ack,
  output isa_pkg::fetched_instr_t instr,
  output logic                    instr_valid,
  input  logic                    instr_taken,
  input  logic                    need_modrm,
  input  logic                    need_operand
);

  import micro_pkg::*;

  fetch_state_e state;
  logic         want_byte;
  logic         take_byte;

  // does the current stage expect a byte at all
  always_comb begin
    case (state)
      fetch_opcode: want_byte = 1'b1;
      fetch_modrm:  want_byte = need_modrm;
      fetch_lo:     want_byte = need_operand;
      fetch_hi:     want_byte = 1'b1;
      default:      want_byte = 1'b0;
    endcase
  end

  // new req only counts once the previous ack has dropped
  assign take_byte   = want_byte && byte_req && !byte_ack;
  assign instr_valid = (state == fetch_done);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= fetch_opcode;
      byte_ack <= 1'b0;
    end else begin
      // four-phase ack, up after req, down after req drops
      if (take_byte) begin
        byte_ack <= 1'b1;
      end else if (byte_ack && !byte_req) begin
        byte_ack <= 1'b0;
      end
      case (state)
        fetch_opcode: if (take_byte) state <= fetch_modrm;
        // skipped stages fall through one cycle each
        fetch_modrm: if (!want_byte || take_byte) state <= fetch_lo;
        fetch_lo: begin
          if (!want_byte) begin
            state <= fetch_done;
          end else if (take_byte) begin
            state <= fetch_hi;
          end
        end
        fetch_hi: if (take_byte) state <= fetch_done;
        // hold until the sequencer starts the routine
        default: if (instr_taken) state <= fetch_opcode;
      endcase
    end
  end

  // instruction assembly
  always_ff @(posedge clk) begin
    if (take_byte) begin
      case (state)
        fetch_opcode: begin
          instr.opcode        <= byte_data;
          instr.operand       <= '0;
          instr.operand_valid <= 1'b0;
        end
        fetch_modrm: instr.modrm <= byte_data;
        fetch_lo:    instr.operand[7:0] <= byte_data;
        default: begin
          instr.operand[15:8] <= byte_data;
          instr.operand_valid <= 1'b1;
        end
      endcase
    end
  end

endmodule

/* rtl/micro_pkg.sv */
package micro_pkg;

  // micro operations understood by the execution unit
  typedef enum logic [3:0] {
    uop_nop        = 4'd0,
    uop_ld_imm     = 4'd1,
    uop_rd_a       = 4'd2,
    uop_rd_b       = 4'd3,
    uop_alu_add    = 4'd4,
    uop_wr_reg     = 4'd5,
    uop_ld_off     = 4'd6,
    uop_jump       = 4'd7,
    uop_halt       = 4'd8,
    // trap and interrupt entry
    uop_push_flags = 4'd9,
    uop_vector     = 4'd10,
    uop_trap_ud    = 4'd11
  } uop_e;

  // word handed to the execution unit
  typedef struct packed {
    uop_e              uop;
    isa_pkg::reg_idx_t src;
    isa_pkg::reg_idx_t dst;
    logic [15:0]       data;
    // final word of the routine
    logic              last;
  } micro_word_t;

  // byte assembler states
  typedef enum logic [2:0] {
    fetch_opcode,
    fetch_modrm,
    fetch_lo,
    fetch_hi,
    fetch_done
  } fetch_state_e;

endpackage

/* rtl/isa_pkg.sv */
`include "cpu_defs.svh"

package isa_pkg;

  // supported opcodes, anything else traps as invalid
  typedef enum logic [7:0] {
    op_add_rm  = 8'h01,
    // register form only, modrm must have mod == 2'b11
    op_nop     = 8'h90,
    op_mov_ri  = 8'hB8,
    // b8..bf, register index in bits 2:0
    op_jmp_rel = 8'hE9,
    op_hlt     = 8'hF4
  } opcode_e;

  // one of the eight 16-bit registers
  typedef logic [2:0] reg_idx_t;

  // instruction as assembled from the byte stream
  typedef struct packed {
    logic [7:0]  opcode;
    logic [7:0]  modrm;
    // imm16 or rel16, little endian on the wire
    logic [15:0] operand;
    logic        operand_valid;
  } fetched_instr_t;

  // result of the opcode table
  typedef struct packed {
    logic [`MICRO_ADDR_WIDTH-1:0] entry;
    reg_idx_t                     src;
    reg_idx_t                     dst;
    // trailing bytes still to be fetched
    logic                         need_modrm;
    logic                         need_operand;
  } decoded_instr_t;

endpackage

/* rtl/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// microcode address space
`define MICRO_ADDR_WIDTH 5
`define ROM_DEPTH        32

// routine entry points in the microcode rom
`define ENTRY_NOP  `MICRO_ADDR_WIDTH'd0
`define ENTRY_MOV  `MICRO_ADDR_WIDTH'd1
`define ENTRY_ADD  `MICRO_ADDR_WIDTH'd3
`define ENTRY_JMP  `MICRO_ADDR_WIDTH'd6
`define ENTRY_HLT  `MICRO_ADDR_WIDTH'd8
`define ENTRY_INV  `MICRO_ADDR_WIDTH'd9
// trap routines sit at the top, anything from EINT up is a trap
`define ENTRY_EINT `MICRO_ADDR_WIDTH'd11
`define ENTRY_INTD `MICRO_ADDR_WIDTH'd14

`endif
